// File: design/exec_pkg.sv
package exec_pkg;

  // ====================
  // ALU opcodes
  // ====================

  // Codes 10 to 15 are not assigned and decode as illegal
  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_SLT = 4'd2,
    ALU_AND = 4'd3,
    ALU_OR  = 4'd4,
    ALU_XOR = 4'd5,
    ALU_NOR = 4'd6,
    ALU_SL  = 4'd7,
    ALU_SR  = 4'd8,
    ALU_LUI = 4'd9
  } alu_op_e;

  // ====================
  // Controller states
  // ====================

  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    EXEC    = 2'd1,
    DONE    = 2'd2,
    RELEASE = 2'd3
  } exec_state_e;

  // ====================
  // Instruction fields
  // ====================

  localparam int OPC_MSB     = 31;
  localparam int OPC_LSB     = 28;
  localparam int SGN_BIT     = 27;
  localparam int IMM_SEL_BIT = 26;
  // Register indices are all five bits wide
  localparam int REG_IDX_W   = 5;
  localparam int RD_LSB      = 0;
  localparam int RJ_LSB      = 5;
  localparam int RK_LSB      = 10;
  // imm12 overlaps rk and imm20 overlaps rj
  localparam int IMM12_MSB   = 21;
  localparam int IMM12_LSB   = 10;
  localparam int IMM20_MSB   = 24;
  localparam int IMM20_LSB   = 5;

endpackage : exec_pkg

// File: design/alu.sv
`timescale 1ns/1ns

module alu (
  input  logic [31:0]       src0_i,
  input  logic [31:0]       src1_i,
  input  logic              signed_i,
  input  exec_pkg::alu_op_e alu_op_i,
  output logic [31:0]       res_o
);

  // Shift amount from the low bits of operand B
  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt = src1_i[4:0];

  // Both compare flavours are built and picked by signed_i
  assign lt_signed   = $signed(src0_i) < $signed(src1_i);
  assign lt_unsigned = src0_i < src1_i;

  always_comb begin
    case (alu_op_i)
      exec_pkg::ALU_ADD: begin
        res_o = src0_i + src1_i;
      end
      exec_pkg::ALU_SUB: begin
        res_o = src0_i - src1_i;
      end
      exec_pkg::ALU_SLT: begin
        // Single bit result, upper bits zero
        res_o = {31'b0, (signed_i ? lt_signed : lt_unsigned)};
      end
      exec_pkg::ALU_AND: begin
        res_o = src0_i & src1_i;
      end
      exec_pkg::ALU_OR: begin
        res_o = src0_i | src1_i;
      end
      exec_pkg::ALU_XOR: begin
        res_o = src0_i ^ src1_i;
      end
      exec_pkg::ALU_NOR: begin
        res_o = ~(src0_i | src1_i);
      end
      exec_pkg::ALU_SL: begin
        res_o = src0_i << shamt;
      end
      exec_pkg::ALU_SR: begin
        // Arithmetic shift keeps the sign bit
        if (signed_i) begin
          res_o = $unsigned($signed(src0_i) >>> shamt);
        end else begin
          res_o = src0_i >> shamt;
        end
      end
      exec_pkg::ALU_LUI: begin
        res_o = src1_i << 12;
      end
      default: begin
        // Unassigned codes
        res_o = 32'b0;
      end
    endcase
  end

endmodule : alu

// File: design/reg_file.sv
`timescale 1ns/1ns

module reg_file #(
  parameter int NUM_REGS = 32
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic [4:0]  raddr0_i,
  input  logic [4:0]  raddr1_i,
  output logic [31:0] rdata0_o,
  output logic [31:0] rdata1_o,
  input  logic        we_i,
  input  logic [4:0]  waddr_i,
  input  logic [31:0] wdata_i
);

  logic [31:0] regs [NUM_REGS];

  // Out of range indices also read zero
  // The decoder flags them before they matter
  assign rdata0_o = (raddr0_i == 5'd0 || int'(raddr0_i) >= NUM_REGS) ?
                    32'b0 : regs[raddr0_i];
  assign rdata1_o = (raddr1_i == 5'd0 || int'(raddr1_i) >= NUM_REGS) ?
                    32'b0 : regs[raddr1_i];

  // ====================
  // Write port
  // ====================

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= 32'b0;
      end
    end else if (we_i && waddr_i != 5'd0 && int'(waddr_i) < NUM_REGS) begin
      // r0 stays zero
      regs[waddr_i] <= wdata_i;
    end
  end

endmodule : reg_file

// File: design/inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder #(
  parameter int NUM_REGS = 32
) (
  input  logic [31:0]       instr_i,
  output exec_pkg::alu_op_e op_o,
  output logic              signed_o,
  output logic              use_imm_o,
  output logic [31:0]       imm_o,
  output logic [4:0]        rj_o,
  output logic [4:0]        rk_o,
  output logic [4:0]        rd_o,
  output logic              illegal_o
);

  logic [3:0]  opc;
  logic        is_lui;
  logic [11:0] imm12;
  logic [19:0] imm20;
  logic        bad_opc;
  logic        bad_rd;
  logic        bad_rj;
  logic        bad_rk;

  // ====================
  // Field extraction
  // ====================

  assign opc      = instr_i[exec_pkg::OPC_MSB:exec_pkg::OPC_LSB];
  assign op_o     = exec_pkg::alu_op_e'(opc);
  assign signed_o = instr_i[exec_pkg::SGN_BIT];

  assign rd_o = instr_i[exec_pkg::RD_LSB +: exec_pkg::REG_IDX_W];
  assign rj_o = instr_i[exec_pkg::RJ_LSB +: exec_pkg::REG_IDX_W];
  assign rk_o = instr_i[exec_pkg::RK_LSB +: exec_pkg::REG_IDX_W];

  assign imm12 = instr_i[exec_pkg::IMM12_MSB:exec_pkg::IMM12_LSB];
  assign imm20 = instr_i[exec_pkg::IMM20_MSB:exec_pkg::IMM20_LSB];

  // LUI always takes the immediate
  assign is_lui    = (op_o == exec_pkg::ALU_LUI);
  assign use_imm_o = is_lui || instr_i[exec_pkg::IMM_SEL_BIT];

  // imm20 zero extended for LUI, imm12 sign extended otherwise
  assign imm_o = is_lui ? {12'b0, imm20} : {{20{imm12[11]}}, imm12};

  // ====================
  // Legality
  // ====================

  assign bad_opc = (opc >= 4'd10);

  // Only indices the form actually reads count
  assign bad_rd = int'(rd_o) >= NUM_REGS;
  // rj bits hold imm20 under LUI
  assign bad_rj = !is_lui && int'(rj_o) >= NUM_REGS;
  // rk bits hold imm12 in immediate forms
  assign bad_rk = !use_imm_o && int'(rk_o) >= NUM_REGS;

  assign illegal_o = bad_opc || bad_rd || bad_rj || bad_rk;

endmodule : inst_decoder

// File: design/exec_ctrl.sv
`timescale 1ns/1ns

module exec_ctrl (
  input  logic        clk_i,
  input  logic        rst_i,
  // Host handshake
  input  logic        req_i,
  input  logic [31:0] instr_i,
  output logic        ack_o,
  output logic [31:0] result_o,
  output logic        err_o,
  // Decoder
  output logic [31:0] instr_o,
  input  logic        illegal_i,
  input  logic        use_imm_i,
  input  logic [31:0] imm_i,
  input  logic [4:0]  rd_i,
  // Operands and ALU
  input  logic [31:0] rdata1_i,
  output logic [31:0] opb_o,
  input  logic [31:0] alu_res_i,
  // Register write
  output logic        we_o,
  output logic [4:0]  waddr_o,
  output logic [31:0] wdata_o
);

  exec_pkg::exec_state_e state_q;
  exec_pkg::exec_state_e state_d;
  logic [31:0]           instr_q;

  // ====================
  // State machine
  // ====================

  always_comb begin
    state_d = state_q;
    case (state_q)
      exec_pkg::IDLE:    if (req_i) state_d = exec_pkg::EXEC;
      exec_pkg::EXEC:    state_d = exec_pkg::DONE;
      // Hold ack until the host lets go
      exec_pkg::DONE:    if (!req_i) state_d = exec_pkg::RELEASE;
      exec_pkg::RELEASE: state_d = exec_pkg::IDLE;
      default:           state_d = exec_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= exec_pkg::IDLE;
      instr_q  <= 32'b0;
      result_o <= 32'b0;
      err_o    <= 1'b0;
    end else begin
      state_q <= state_d;
      // Latch the word on acceptance
      if (state_q == exec_pkg::IDLE && req_i) begin
        instr_q <= instr_i;
      end
      // Capture result on the execute edge
      if (state_q == exec_pkg::EXEC) begin
        result_o <= illegal_i ? 32'b0 : alu_res_i;
        err_o    <= illegal_i;
      end
    end
  end

  assign instr_o = instr_q;
  assign ack_o   = (state_q == exec_pkg::DONE);

  // Operand B mux
  assign opb_o = use_imm_i ? imm_i : rdata1_i;

  // ====================
  // Writeback
  // ====================

  // Same edge as the result capture
  assign we_o    = (state_q == exec_pkg::EXEC) && !illegal_i && (rd_i != 5'd0);
  assign waddr_o = rd_i;
  assign wdata_o = alu_res_i;

endmodule : exec_ctrl

// File: design/exec_unit.sv
`timescale 1ns/1ns

module exec_unit #(
  parameter int NUM_REGS = 32
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        req_i,
  input  logic [31:0] instr_i,
  output logic        ack_o,
  output logic [31:0] result_o,
  output logic        err_o
);

  // Decoded fields
  logic [31:0]       instr_q;
  exec_pkg::alu_op_e op;
  logic              signed_op;
  logic              use_imm;
  logic [31:0]       imm;
  logic [4:0]        rj;
  logic [4:0]        rk;
  logic [4:0]        rd;
  logic              illegal;

  // Datapath
  logic [31:0] rdata0;
  logic [31:0] rdata1;
  logic [31:0] opb;
  logic [31:0] alu_res;
  logic        we;
  logic [4:0]  waddr;
  logic [31:0] wdata;

  exec_ctrl ctrl_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .req_i     (req_i),
    .instr_i   (instr_i),
    .ack_o     (ack_o),
    .result_o  (result_o),
    .err_o     (err_o),
    .instr_o   (instr_q),
    .illegal_i (illegal),
    .use_imm_i (use_imm),
    .imm_i     (imm),
    .rd_i      (rd),
    .rdata1_i  (rdata1),
    .opb_o     (opb),
    .alu_res_i (alu_res),
    .we_o      (we),
    .waddr_o   (waddr),
    .wdata_o   (wdata)
  );

  inst_decoder #(
    .NUM_REGS (NUM_REGS)
  ) decoder_i (
    .instr_i   (instr_q),
    .op_o      (op),
    .signed_o  (signed_op),
    .use_imm_o (use_imm),
    .imm_o     (imm),
    .rj_o      (rj),
    .rk_o      (rk),
    .rd_o      (rd),
    .illegal_o (illegal)
  );

  // Port 0 feeds operand A, port 1 goes through the operand mux
  reg_file #(
    .NUM_REGS (NUM_REGS)
  ) reg_file_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .raddr0_i (rj),
    .raddr1_i (rk),
    .rdata0_o (rdata0),
    .rdata1_o (rdata1),
    .we_i     (we),
    .waddr_i  (waddr),
    .wdata_i  (wdata)
  );

  alu alu_i (
    .src0_i   (rdata0),
    .src1_i   (opb),
    .signed_i (signed_op),
    .alu_op_i (op),
    .res_o    (alu_res)
  );

endmodule : exec_unit

// File: verification/exec_unit_tb.sv
`timescale 1ns/1ns

module exec_unit_tb #(
  parameter int NUM_REGS = 32
);

  localparam int TIMEOUT = 50;

  logic        clk_i;
  logic        rst_i;
  logic        req_i;
  logic [31:0] instr_i;
  logic        ack_o;
  logic [31:0] result_o;
  logic        err_o;

  // Expected register contents
  logic [31:0] model_regs [32];
  int          seed = 32'h3948;
  int          errors = 0;

  exec_unit #(
    .NUM_REGS (NUM_REGS)
  ) exec_unit_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .req_i    (req_i),
    .instr_i  (instr_i),
    .ack_o    (ack_o),
    .result_o (result_o),
    .err_o    (err_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ====================
  // Reporting
  // ====================

  task automatic abort_run(input string msg);
    errors++;
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "run aborted");
  endtask

  task automatic check_result(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      errors++;
      $display("** Error %s: expected %h actual %h", name, exp, act);
      $display("Test failures found");
      $fatal(1, "%s result mismatch", name);
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("** Error %s: expected %b actual %b", name, exp, act);
      $display("Test failures found");
      $fatal(1, "%s error flag mismatch", name);
    end
  endtask

  // ====================
  // Instruction builders
  // ====================

  function automatic logic [31:0] enc_reg(logic [3:0] opc, logic sgn, int rd, int rj, int rk);
    logic [31:0] w;
    w = 32'b0;
    w[exec_pkg::OPC_MSB:exec_pkg::OPC_LSB] = opc;
    w[exec_pkg::SGN_BIT] = sgn;
    w[exec_pkg::RD_LSB +: exec_pkg::REG_IDX_W] = 5'(rd);
    w[exec_pkg::RJ_LSB +: exec_pkg::REG_IDX_W] = 5'(rj);
    w[exec_pkg::RK_LSB +: exec_pkg::REG_IDX_W] = 5'(rk);
    return w;
  endfunction

  // Immediate form with imm12 on top of rk
  function automatic logic [31:0] enc_imm(logic [3:0] opc, logic sgn, int rd, int rj,
                                          logic [11:0] imm12);
    logic [31:0] w;
    w = enc_reg(opc, sgn, rd, rj, 0);
    w[exec_pkg::IMM_SEL_BIT] = 1'b1;
    w[exec_pkg::IMM12_MSB:exec_pkg::IMM12_LSB] = imm12;
    return w;
  endfunction

  function automatic logic [31:0] enc_lui(int rd, logic [19:0] imm20);
    logic [31:0] w;
    w = enc_reg(exec_pkg::ALU_LUI, 1'b0, rd, 0, 0);
    w[exec_pkg::IMM20_MSB:exec_pkg::IMM20_LSB] = imm20;
    return w;
  endfunction

  // ====================
  // Reference model
  // ====================

  function automatic logic [31:0] model_alu(logic [3:0] opc, logic sgn, logic [31:0] a,
                                            logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (opc)
      exec_pkg::ALU_ADD: return a + b;
      exec_pkg::ALU_SUB: return a - b;
      // Flipping the sign bits turns a signed compare into an unsigned one
      exec_pkg::ALU_SLT: return sgn ? 32'((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) :
                                      32'(a < b);
      exec_pkg::ALU_AND: return a & b;
      exec_pkg::ALU_OR:  return a | b;
      exec_pkg::ALU_XOR: return a ^ b;
      exec_pkg::ALU_NOR: return ~(a | b);
      exec_pkg::ALU_SL:  return a << sh;
      // Sign fill for the vacated upper bits
      exec_pkg::ALU_SR:  return (a >> sh) | ((sgn && a[31]) ? ~(32'hffff_ffff >> sh) : 32'h0);
      exec_pkg::ALU_LUI: return b << 12;
      default:           return 32'h0;
    endcase
  endfunction

  // ====================
  // Host side
  // ====================

  // Full four-phase transfer with ack three falling edges after the drive edge
  task automatic issue(input logic [31:0] word, input int hold, output logic [31:0] res,
                       output logic err);
    int n;
    n = 0;
    @(negedge clk_i);
    while (ack_o !== 1'b0) begin
      @(negedge clk_i);
      n++;
      if (n > TIMEOUT) abort_run("ack_o stayed high before a new request");
    end
    @(posedge clk_i);
    req_i   <= 1'b1;
    instr_i <= word;
    n = 0;
    while (ack_o !== 1'b1) begin
      @(negedge clk_i);
      n++;
      if (n > TIMEOUT) abort_run("ack_o never rose after req_i was raised");
    end
    if (n != 3) abort_run("ack_o did not rise two edges after req_i was sampled");
    res = result_o;
    err = err_o;
    // Outputs must hold under back-pressure
    repeat (hold) begin
      @(negedge clk_i);
      if (ack_o !== 1'b1 || result_o !== res || err_o !== err) begin
        abort_run("ack_o or the result changed while req_i was held high");
      end
    end
    @(posedge clk_i);
    req_i <= 1'b0;
    n = 0;
    while (ack_o !== 1'b0) begin
      @(negedge clk_i);
      n++;
      if (n > TIMEOUT) abort_run("ack_o never fell after req_i dropped");
    end
  endtask

  // Predict, issue, compare, then update the model
  task automatic run_instr(input string name, input logic [31:0] word, input int hold);
    logic [3:0]  opc;
    logic        sgn;
    logic        is_lui;
    logic        use_imm;
    int          rd;
    int          rj;
    int          rk;
    logic [31:0] imm;
    logic        bad;
    logic [31:0] exp_res;
    logic        exp_err;
    logic [31:0] act_res;
    logic        act_err;
    opc     = word[exec_pkg::OPC_MSB:exec_pkg::OPC_LSB];
    sgn     = word[exec_pkg::SGN_BIT];
    is_lui  = (opc == exec_pkg::ALU_LUI);
    use_imm = is_lui || word[exec_pkg::IMM_SEL_BIT];
    rd      = int'(word[exec_pkg::RD_LSB +: exec_pkg::REG_IDX_W]);
    rj      = int'(word[exec_pkg::RJ_LSB +: exec_pkg::REG_IDX_W]);
    rk      = int'(word[exec_pkg::RK_LSB +: exec_pkg::REG_IDX_W]);
    imm     = is_lui ? {12'b0, word[exec_pkg::IMM20_MSB:exec_pkg::IMM20_LSB]} :
                       32'($signed(word[exec_pkg::IMM12_MSB:exec_pkg::IMM12_LSB]));
    // Only indices that the form reads count
    bad = (opc >= 4'd10) || (rd >= NUM_REGS) || (!is_lui && rj >= NUM_REGS) ||
          (!use_imm && rk >= NUM_REGS);
    exp_err = bad;
    exp_res = bad ? 32'h0 : model_alu(opc, sgn, model_regs[rj], use_imm ? imm : model_regs[rk]);
    issue(word, hold, act_res, act_err);
    check_result(name, exp_res, act_res);
    check_err(name, exp_err, act_err);
    if (!bad && rd != 0) model_regs[rd] = exp_res;
  endtask

  // Any 32-bit value through LUI then ADD immediate
  task automatic load_reg(input string name, input int r, input logic [31:0] value);
    logic [31:0] hi;
    hi = value - 32'($signed(value[11:0]));
    run_instr(name, enc_lui(r, hi[31:12]), 0);
    run_instr(name, enc_imm(exec_pkg::ALU_ADD, 1'b0, r, r, value[11:0]), 0);
  endtask

  // ====================
  // Tests
  // ====================

  task automatic test_latency();
    @(negedge clk_i);
    if (ack_o !== 1'b0) abort_run("ack_o is high after reset");
    run_instr("latency_nohold", enc_imm(exec_pkg::ALU_ADD, 1'b0, 1, 0, 12'h123), 0);
    run_instr("latency_hold", enc_imm(exec_pkg::ALU_ADD, 1'b0, 2, 1, 12'hf00), 4);
  endtask

  task automatic test_arith();
    run_instr("arith_load_max", enc_imm(exec_pkg::ALU_ADD, 1'b0, 1, 0, 12'h7ff), 0);
    run_instr("arith_load_min", enc_imm(exec_pkg::ALU_ADD, 1'b0, 2, 0, 12'h800), 0);
    for (int i = 0; i < 8; i++) begin
      load_reg("arith_load", 3, $random(seed));
      load_reg("arith_load", 4, $random(seed));
      // Opcodes 0 to 6 without SLT
      for (int j = 0; j < 7; j++) begin
        if (j != 2) run_instr($sformatf("arith_op%0d", j), enc_reg(4'(j), 1'b0, 5 + j, 3, 4), 0);
      end
    end
    run_instr("arith_small", enc_reg(exec_pkg::ALU_SUB, 1'b0, 11, 1, 2), 0);
  endtask

  task automatic test_cmp_shift();
    load_reg("cmp_load", 3, $random(seed) | 32'h8000_0000);
    load_reg("cmp_load", 4, $random(seed) & 32'h7fff_ffff);
    for (int s = 0; s < 2; s++) begin
      run_instr("slt_neg_pos", enc_reg(exec_pkg::ALU_SLT, 1'(s), 5, 3, 4), 0);
      run_instr("slt_pos_neg", enc_reg(exec_pkg::ALU_SLT, 1'(s), 6, 4, 3), 0);
      run_instr("sr_imm", enc_imm(exec_pkg::ALU_SR, 1'(s), 7, 3, 12'($random(seed) & 31)), 0);
      run_instr("sr_reg", enc_reg(exec_pkg::ALU_SR, 1'(s), 8, 3, 4), 0);
    end
    run_instr("sl_0", enc_imm(exec_pkg::ALU_SL, 1'b0, 9, 3, 12'd0), 0);
    run_instr("sl_1", enc_imm(exec_pkg::ALU_SL, 1'b0, 9, 3, 12'd1), 0);
    run_instr("sl_31", enc_imm(exec_pkg::ALU_SL, 1'b0, 9, 3, 12'd31), 0);
    run_instr("lui", enc_lui(10, 20'($random(seed))), 0);
  endtask

  task automatic test_r0();
    // Sum still comes back but the write is dropped
    run_instr("r0_write", enc_imm(exec_pkg::ALU_ADD, 1'b0, 0, 3, 12'h055), 0);
    run_instr("r0_read_rj", enc_reg(exec_pkg::ALU_ADD, 1'b0, 11, 0, 3), 0);
    run_instr("r0_read_rk", enc_reg(exec_pkg::ALU_ADD, 1'b0, 12, 4, 0), 0);
  endtask

  task automatic test_illegal();
    // Destination r3 holds a nonzero value, so a stray write of zero shows up
    run_instr("illegal_opc", enc_reg(4'd12, 1'b0, 3, 3, 4), 0);
    run_instr("illegal_opc_keep", enc_reg(exec_pkg::ALU_ADD, 1'b0, 13, 3, 0), 0);
    // High indices are legal only in the 32-register build
    run_instr("illegal_rd", enc_reg(exec_pkg::ALU_ADD, 1'b0, 20, 3, 4), 0);
    run_instr("illegal_rj", enc_reg(exec_pkg::ALU_XOR, 1'b0, 9, 17, 4), 0);
    run_instr("illegal_rk", enc_reg(exec_pkg::ALU_OR, 1'b0, 9, 3, 30), 0);
    run_instr("illegal_idx_keep", enc_reg(exec_pkg::ALU_ADD, 1'b0, 14, 9, 0), 0);
  endtask

  initial begin
    rst_i   = 1'b1;
    req_i   = 1'b0;
    instr_i = 32'b0;
    for (int i = 0; i < 32; i++) model_regs[i] = 32'b0;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
    test_latency();
    test_arith();
    test_cmp_shift();
    test_r0();
    test_illegal();
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule : exec_unit_tb

// File: src.f
design/exec_pkg.sv
design/alu.sv
design/reg_file.sv
design/inst_decoder.sv
design/exec_ctrl.sv
design/exec_unit.sv
verification/exec_unit_tb.sv

// File: Bender.yml
package:
  name: exec_unit

sources:
  - files:
      - design/exec_pkg.sv
      - design/alu.sv
      - design/reg_file.sv
      - design/inst_decoder.sv
      - design/exec_ctrl.sv
      - design/exec_unit.sv
  - target: test
    files:
      - verification/exec_unit_tb.sv
